//--- list.f
+incdir+.
vision_pkg.sv
skin_pixel_capture.sv
region_box_tracker.sv
box_sampler.sv
box_area_filter.sv
box_overlay.sv
skin_box_overlay_top.sv
tb_skin_box_overlay.sv

//--- tb_frame_tasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

    logic [31:0] rng_state = 32'ha78a;

    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic bit patch_active(int pat, int i);
        return (rpat[i] == pat) || (rpat[i] == 2);
    endfunction

    function automatic bit in_patch(int pat, int x, int y);
        for (int i = 0; i < 6; i++) begin
            if (patch_active(pat, i) && x >= rx0[i] && x <= rx1[i] &&
                y >= ry0[i] && y <= ry1[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Strobes needed on a line, 0 for an empty line
    function automatic int line_length(int pat, int y);
        int len;
        len = 0;
        for (int i = 0; i < 6; i++) begin
            if (patch_active(pat, i) && y >= ry0[i] && y <= ry1[i] && rx1[i] + 1 > len) begin
                len = rx1[i] + 1;
            end
        end
        for (int j = 0; j < 3; j++) begin
            if (my[j] == y && mx[j] + 1 > len) begin
                len = mx[j] + 1;
            end
        end
        return len;
    endfunction

    function automatic int last_line(int pat);
        int last;
        last = 0;
        for (int y = 0; y < FRAME_H; y++) begin
            if (line_length(pat, y) > 0) begin
                last = y;
            end
        end
        return last;
    endfunction

    function automatic int frame_cycles(int pat);
        int total;
        total = 7;
        for (int y = 0; y <= last_line(pat); y++) begin
            total += (line_length(pat, y) == 0) ? 2 : line_length(pat, y) + 1;
        end
        return total;
    endfunction

    // Skin inside patches, near misses at fixed spots, far chroma elsewhere
    task automatic pixel_chroma(int pat, int x, int y, output chroma_t cu, output chroma_t cv);
        int off;
        off = 17 + int'(next_rand() % 223);
        cu = chroma_t'(int'(u_ref) + off);
        cv = chroma_t'(next_rand());
        if (in_patch(pat, x, y)) begin
            cu = chroma_t'(int'(u_ref) + int'(next_rand() % 33) - 16);
            cv = chroma_t'(int'(v_ref) + int'(next_rand() % 33) - 16);
        end
        for (int j = 0; j < 3; j++) begin
            if (mx[j] == x && my[j] == y) begin
                cu = chroma_t'(int'(u_ref) + mdu[j]);
                cv = chroma_t'(int'(v_ref) + mdv[j]);
            end
        end
    endtask

    task automatic send_frame(int pat);
        int len;
        chroma_t cu;
        chroma_t cv;
        for (int y = 0; y <= last_line(pat); y++) begin
            len = line_length(pat, y);
            href = 1'b1;
            if (len == 0) begin
                next_cycle();
            end
            for (int x = 0; x < len; x++) begin
                pixel_chroma(pat, x, y, cu, cv);
                u = cu;
                v = cv;
                pix_stb = 1'b1;
                record_pixel(x, y, cu, cv);
                next_cycle();
            end
            href = 1'b0;
            pix_stb = 1'b0;
            next_cycle();
        end
        repeat (3) next_cycle();
        // Rising vsync closes the frame
        vsync = 1'b1;
        record_frame_end();
        repeat (2) next_cycle();
        vsync = 1'b0;
        repeat (2) next_cycle();
    endtask

`endif

//--- tb_skin_box_overlay.sv
module tb_skin_box_overlay;
    import vision_pkg::*;

    logic          clk = 1'b0;
    logic          reset;
    logic          vsync, href, pix_stb;
    chroma_t       u, v, u_ref, v_ref;
    thresh_t       area_thresh;
    overlay_mode_e mode;
    coord_t        draw_x, draw_y;
    luma_t         luma, red, green, blue;

    int check_cnt = 0;
    int error_cnt = 0;
    int cycle_cnt = 0;
    int cycle_limit = 1000000;

    // Skin patches and the pattern each belongs to (2 for both)
    int rx0 [6] = '{10, 170, 500, 330, 632, 200};
    int ry0 [6] = '{10, 170, 400, 30, 60, 250};
    int rx1 [6] = '{19, 189, 511, 333, 651, 215};
    int ry1 [6] = '{17, 181, 407, 32, 63, 261};
    int rpat [6] = '{0, 0, 0, 0, 2, 1};
    // Near misses with chroma offsets just past the tolerance
    int mx [3] = '{22, 5, 15};
    int my [3] = '{12, 14, 20};
    int mdu [3] = '{17, 0, -17};
    int mdv [3] = '{0, -17, 5};
    // Scan windows around every patch position
    int wx0 [6] = '{0, 165, 495, 325, 626, 195};
    int wy0 [6] = '{5, 165, 395, 25, 55, 245};
    int wx1 [6] = '{25, 194, 516, 338, 645, 220};
    int wy1 [6] = '{24, 186, 412, 37, 68, 266};

    // Expected boxes of the running frame and of the last latch
    int fr_min_x [REGION_COUNT], fr_max_x [REGION_COUNT];
    int fr_min_y [REGION_COUNT], fr_max_y [REGION_COUNT];
    int lt_min_x [REGION_COUNT], lt_max_x [REGION_COUNT];
    int lt_min_y [REGION_COUNT], lt_max_y [REGION_COUNT];
    int frame_cnt = 0;

    skin_box_overlay_top skin_box_overlay_top_i (
        .clk(clk), .reset(reset),
        .vsync_i(vsync), .href_i(href), .pix_stb_i(pix_stb),
        .u_i(u), .v_i(v), .u_ref_i(u_ref), .v_ref_i(v_ref),
        .area_thresh_i(area_thresh), .mode_i(mode),
        .draw_x_i(draw_x), .draw_y_i(draw_y), .luma_i(luma),
        .red_o(red), .green_o(green), .blue_o(blue)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    `include "tb_frame_tasks.svh"

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // All running and latched boxes empty, as after reset
    task automatic clear_model();
        for (int r = 0; r < REGION_COUNT; r++) begin
            fr_min_x[r] = COORD_EMPTY;
            fr_max_x[r] = 0;
            fr_min_y[r] = COORD_EMPTY;
            fr_max_y[r] = 0;
            lt_min_x[r] = COORD_EMPTY;
            lt_max_x[r] = 0;
            lt_min_y[r] = COORD_EMPTY;
            lt_max_y[r] = 0;
        end
    endtask

    task automatic record_pixel(int x, int y, chroma_t cu, chroma_t cv);
        int du;
        int dv;
        int r;
        du = int'(cu) - int'(u_ref);
        dv = int'(cv) - int'(v_ref);
        if (du < 0) du = -du;
        if (dv < 0) dv = -dv;
        if (x < FRAME_W && y < FRAME_H && du <= CHROMA_TOL && dv <= CHROMA_TOL) begin
            r = (y / REGION_SIZE) * REGION_COLS + x / REGION_SIZE;
            if (x < fr_min_x[r]) fr_min_x[r] = x;
            if (x > fr_max_x[r]) fr_max_x[r] = x;
            if (y < fr_min_y[r]) fr_min_y[r] = y;
            if (y > fr_max_y[r]) fr_max_y[r] = y;
        end
    endtask

    task automatic record_frame_end();
        frame_cnt++;
        for (int r = 0; r < REGION_COUNT; r++) begin
            if (frame_cnt % SAMPLE_PERIOD == 0) begin
                lt_min_x[r] = fr_min_x[r];
                lt_max_x[r] = fr_max_x[r];
                lt_min_y[r] = fr_min_y[r];
                lt_max_y[r] = fr_max_y[r];
            end
            fr_min_x[r] = COORD_EMPTY;
            fr_max_x[r] = 0;
            fr_min_y[r] = COORD_EMPTY;
            fr_max_y[r] = 0;
        end
    endtask

    function automatic bit expect_edge(int x, int y);
        int eff;
        int area;
        bit hit;
        eff = (area_thresh == 0) ? int'(AREA_THRESH_DEFAULT) : int'(area_thresh);
        hit = 1'b0;
        for (int r = 0; r < REGION_COUNT; r++) begin
            area = (lt_max_x[r] - lt_min_x[r] + 1) * (lt_max_y[r] - lt_min_y[r] + 1);
            if (lt_min_x[r] != COORD_EMPTY && lt_min_y[r] != COORD_EMPTY &&
                lt_max_x[r] >= lt_min_x[r] && lt_max_y[r] >= lt_min_y[r] && area >= eff) begin
                if (((y == lt_min_y[r] || y == lt_max_y[r]) &&
                     x >= lt_min_x[r] && x <= lt_max_x[r]) ||
                    ((x == lt_min_x[r] || x == lt_max_x[r]) &&
                     y >= lt_min_y[r] && y <= lt_max_y[r])) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    task automatic scan_window(int x0, int y0, int x1, int y1);
        luma_t exp_r;
        luma_t exp_g;
        luma_t exp_b;
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                draw_x = coord_t'(x);
                draw_y = coord_t'(y);
                luma = luma_t'(next_rand());
                exp_r = luma;
                exp_g = luma;
                exp_b = luma;
                if (mode == OVERLAY_RED && expect_edge(x, y)) begin
                    exp_r = 7'd127;
                    exp_g = 7'd0;
                    exp_b = 7'd0;
                end
                next_cycle();
                check_cnt++;
                assert (red == exp_r && green == exp_g && blue == exp_b) else begin
                    error_cnt++;
                    $display("error %0t: pixel (%0d,%0d) gave rgb %0d/%0d/%0d, %s %0d/%0d/%0d",
                             $time, x, y, red, green, blue, "expected",
                             exp_r, exp_g, exp_b);
                end
            end
        end
    endtask

    task automatic scan_all();
        repeat (4) next_cycle();
        for (int w = 0; w < 6; w++) begin
            scan_window(wx0[w], wy0[w], wx1[w], wy1[w]);
        end
    endtask

    function automatic int scan_cycles();
        int total;
        total = 4;
        for (int w = 0; w < 6; w++) begin
            total += (wx1[w] - wx0[w] + 1) * (wy1[w] - wy0[w] + 1);
        end
        return total;
    endfunction

    initial begin
        cycle_limit = 2 * (10 + 10 * frame_cycles(0) + 5 * frame_cycles(1) + 6 * scan_cycles());
        reset = 1'b1;
        vsync = 1'b0;
        href = 1'b0;
        pix_stb = 1'b0;
        u = '0;
        v = '0;
        u_ref = 8'h70;
        v_ref = 8'h90;
        area_thresh = '0;
        mode = OVERLAY_RED;
        draw_x = '0;
        draw_y = '0;
        luma = '0;
        frame_cnt = 0;
        clear_model();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Four frames leave the sampler untouched
        repeat (4) send_frame(0);
        scan_all();
        send_frame(0);
        scan_all();

        // Small patch kept under a lower threshold
        area_thresh = 16'd10;
        repeat (5) send_frame(0);
        scan_all();
        area_thresh = 16'd1000;
        scan_all();
        area_thresh = '0;
        mode = OVERLAY_OFF;
        scan_all();

        // Moved patch
        mode = OVERLAY_RED;
        repeat (5) send_frame(1);
        scan_all();

        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- skin_box_overlay_top.sv
module skin_box_overlay_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     vsync_i,
    input  logic                     href_i,
    input  logic                     pix_stb_i,
    input  vision_pkg::chroma_t       u_i,
    input  vision_pkg::chroma_t       v_i,
    input  vision_pkg::chroma_t       u_ref_i,
    input  vision_pkg::chroma_t       v_ref_i,
    input  vision_pkg::thresh_t       area_thresh_i,
    input  vision_pkg::overlay_mode_e mode_i,
    input  vision_pkg::coord_t        draw_x_i,
    input  vision_pkg::coord_t        draw_y_i,
    input  vision_pkg::luma_t         luma_i,
    output vision_pkg::luma_t         red_o,
    output vision_pkg::luma_t         green_o,
    output vision_pkg::luma_t         blue_o
);
    import vision_pkg::*;

    logic   hit_stb;
    logic   frame_end_stb;
    coord_t hit_x;
    coord_t hit_y;

    // Running boxes of the current frame
    coord_t trk_min_x [REGION_COUNT];
    coord_t trk_max_x [REGION_COUNT];
    coord_t trk_min_y [REGION_COUNT];
    coord_t trk_max_y [REGION_COUNT];

    // Boxes latched every fifth frame
    coord_t smp_min_x [REGION_COUNT];
    coord_t smp_max_x [REGION_COUNT];
    coord_t smp_min_y [REGION_COUNT];
    coord_t smp_max_y [REGION_COUNT];

    coord_t flt_min_x [REGION_COUNT];
    coord_t flt_max_x [REGION_COUNT];
    coord_t flt_min_y [REGION_COUNT];
    coord_t flt_max_y [REGION_COUNT];
    logic   box_valid [REGION_COUNT];

    skin_pixel_capture capture_i (
        .clk(clk), .reset(reset),
        .vsync_i(vsync_i), .href_i(href_i), .pix_stb_i(pix_stb_i),
        .u_i(u_i), .v_i(v_i), .u_ref_i(u_ref_i), .v_ref_i(v_ref_i),
        .hit_stb_o(hit_stb), .frame_end_o(frame_end_stb),
        .hit_x_o(hit_x), .hit_y_o(hit_y)
    );

    region_box_tracker tracker_i (
        .clk(clk), .reset(reset),
        .hit_stb_i(hit_stb), .frame_end_i(frame_end_stb),
        .hit_x_i(hit_x), .hit_y_i(hit_y),
        .min_x_o(trk_min_x), .max_x_o(trk_max_x),
        .min_y_o(trk_min_y), .max_y_o(trk_max_y)
    );

    box_sampler sampler_i (
        .clk(clk), .reset(reset), .frame_end_i(frame_end_stb),
        .min_x_i(trk_min_x), .max_x_i(trk_max_x),
        .min_y_i(trk_min_y), .max_y_i(trk_max_y),
        .min_x_o(smp_min_x), .max_x_o(smp_max_x),
        .min_y_o(smp_min_y), .max_y_o(smp_max_y)
    );

    box_area_filter filter_i (
        .clk(clk), .reset(reset), .area_thresh_i(area_thresh_i),
        .min_x_i(smp_min_x), .max_x_i(smp_max_x),
        .min_y_i(smp_min_y), .max_y_i(smp_max_y),
        .min_x_o(flt_min_x), .max_x_o(flt_max_x),
        .min_y_o(flt_min_y), .max_y_o(flt_max_y),
        .box_valid_o(box_valid)
    );

    box_overlay overlay_i (
        .clk(clk), .reset(reset), .mode_i(mode_i),
        .draw_x_i(draw_x_i), .draw_y_i(draw_y_i), .luma_i(luma_i),
        .min_x_i(flt_min_x), .max_x_i(flt_max_x),
        .min_y_i(flt_min_y), .max_y_i(flt_max_y),
        .box_valid_i(box_valid),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o)
    );

endmodule

//--- box_overlay.sv
module box_overlay (
    input  logic                     clk,
    input  logic                     reset,
    input  vision_pkg::overlay_mode_e mode_i,
    input  vision_pkg::coord_t        draw_x_i,
    input  vision_pkg::coord_t        draw_y_i,
    input  vision_pkg::luma_t         luma_i,
    input  vision_pkg::coord_t        min_x_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t        max_x_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t        min_y_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t        max_y_i [vision_pkg::REGION_COUNT],
    input  logic                     box_valid_i [vision_pkg::REGION_COUNT],
    output vision_pkg::luma_t         red_o,
    output vision_pkg::luma_t         green_o,
    output vision_pkg::luma_t         blue_o
);
    import vision_pkg::*;

    logic span_x [REGION_COUNT];
    logic span_y [REGION_COUNT];
    logic edge_hit [REGION_COUNT];
    logic on_edge;
    logic paint;

    ////////////////////////////////
    // Edge test over all regions
    ////////////////////////////////

    always_comb begin
        on_edge = 1'b0;
        for (int r = 0; r < REGION_COUNT; r++) begin
            span_x[r] = (draw_x_i >= min_x_i[r]) && (draw_x_i <= max_x_i[r]);
            span_y[r] = (draw_y_i >= min_y_i[r]) && (draw_y_i <= max_y_i[r]);
            // Horizontal edges, then vertical edges
            edge_hit[r] = box_valid_i[r] &&
                          ((((draw_y_i == min_y_i[r]) || (draw_y_i == max_y_i[r])) && span_x[r]) ||
                           (((draw_x_i == min_x_i[r]) || (draw_x_i == max_x_i[r])) && span_y[r]));
            on_edge = on_edge | edge_hit[r];
        end
    end

    assign paint = on_edge && (mode_i == OVERLAY_RED);

    ////////////////////////////////
    // Output colour
    ////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else if (paint) begin
            red_o   <= '1;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            red_o   <= luma_i;
            green_o <= luma_i;
            blue_o  <= luma_i;
        end
    end

endmodule

//--- box_area_filter.sv
module box_area_filter (
    input  logic               clk,
    input  logic               reset,
    input  vision_pkg::thresh_t area_thresh_i,
    input  vision_pkg::coord_t  min_x_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t  max_x_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t  min_y_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t  max_y_i [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t  min_x_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t  max_x_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t  min_y_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t  max_y_o [vision_pkg::REGION_COUNT],
    output logic               box_valid_o [vision_pkg::REGION_COUNT]
);
    import vision_pkg::*;

    thresh_t     thresh_eff;
    logic [10:0] box_w [REGION_COUNT];
    logic [10:0] box_h [REGION_COUNT];
    area_t       box_area [REGION_COUNT];
    logic        box_exists [REGION_COUNT];
    logic        box_keep [REGION_COUNT];

    // Zero on the threshold input selects the default
    assign thresh_eff = (area_thresh_i == '0) ? AREA_THRESH_DEFAULT : area_thresh_i;

    always_comb begin
        for (int r = 0; r < REGION_COUNT; r++) begin
            box_exists[r] = (min_x_i[r] != COORD_EMPTY) && (min_y_i[r] != COORD_EMPTY) &&
                            (max_x_i[r] >= min_x_i[r]) && (max_y_i[r] >= min_y_i[r]);
            box_w[r]    = 11'(max_x_i[r]) - 11'(min_x_i[r]) + 11'd1;
            box_h[r]    = 11'(max_y_i[r]) - 11'(min_y_i[r]) + 11'd1;
            box_area[r] = area_t'(box_w[r]) * area_t'(box_h[r]);
            box_keep[r] = box_exists[r] && (box_area[r] >= area_t'(thresh_eff));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < REGION_COUNT; r++) begin
                min_x_o[r]     <= COORD_EMPTY;
                max_x_o[r]     <= '0;
                min_y_o[r]     <= COORD_EMPTY;
                max_y_o[r]     <= '0;
                box_valid_o[r] <= 1'b0;
            end
        end else begin
            min_x_o     <= min_x_i;
            max_x_o     <= max_x_i;
            min_y_o     <= min_y_i;
            max_y_o     <= max_y_i;
            box_valid_o <= box_keep;
        end
    end

endmodule

//--- box_sampler.sv
module box_sampler (
    input  logic              clk,
    input  logic              reset,
    input  logic              frame_end_i,
    input  vision_pkg::coord_t min_x_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t max_x_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t min_y_i [vision_pkg::REGION_COUNT],
    input  vision_pkg::coord_t max_y_i [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t min_x_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t max_x_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t min_y_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t max_y_o [vision_pkg::REGION_COUNT]
);
    import vision_pkg::*;

    logic [2:0] frame_cnt;
    logic       latch_now;

    assign latch_now = frame_end_i && (frame_cnt == 3'(SAMPLE_PERIOD - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
            for (int r = 0; r < REGION_COUNT; r++) begin
                min_x_o[r] <= COORD_EMPTY;
                max_x_o[r] <= '0;
                min_y_o[r] <= COORD_EMPTY;
                max_y_o[r] <= '0;
            end
        end else if (latch_now) begin
            frame_cnt <= '0;
            min_x_o   <= min_x_i;
            max_x_o   <= max_x_i;
            min_y_o   <= min_y_i;
            max_y_o   <= max_y_i;
        end else if (frame_end_i) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

//--- region_box_tracker.sv
module region_box_tracker (
    input  logic              clk,
    input  logic              reset,
    input  logic              hit_stb_i,
    input  logic              frame_end_i,
    input  vision_pkg::coord_t hit_x_i,
    input  vision_pkg::coord_t hit_y_i,
    output vision_pkg::coord_t min_x_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t max_x_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t min_y_o [vision_pkg::REGION_COUNT],
    output vision_pkg::coord_t max_y_o [vision_pkg::REGION_COUNT]
);
    import vision_pkg::*;

    logic [1:0] hit_col;
    logic [1:0] hit_row;
    logic [3:0] region_idx;

    // Region grid lookup
    assign hit_col    = 2'(hit_x_i / REGION_SIZE);
    assign hit_row    = 2'(hit_y_i / REGION_SIZE);
    assign region_idx = 4'(hit_row * REGION_COLS + hit_col);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < REGION_COUNT; r++) begin
                min_x_o[r] <= COORD_EMPTY;
                max_x_o[r] <= '0;
                min_y_o[r] <= COORD_EMPTY;
                max_y_o[r] <= '0;
            end
        end else if (frame_end_i) begin
            // Completed boxes stay visible during the strobe cycle
            for (int r = 0; r < REGION_COUNT; r++) begin
                min_x_o[r] <= COORD_EMPTY;
                max_x_o[r] <= '0;
                min_y_o[r] <= COORD_EMPTY;
                max_y_o[r] <= '0;
            end
        end else if (hit_stb_i) begin
            if (hit_x_i < min_x_o[region_idx]) begin
                min_x_o[region_idx] <= hit_x_i;
            end
            if (hit_x_i > max_x_o[region_idx]) begin
                max_x_o[region_idx] <= hit_x_i;
            end
            if (hit_y_i < min_y_o[region_idx]) begin
                min_y_o[region_idx] <= hit_y_i;
            end
            if (hit_y_i > max_y_o[region_idx]) begin
                max_y_o[region_idx] <= hit_y_i;
            end
        end
    end

endmodule

//--- skin_pixel_capture.sv
module skin_pixel_capture (
    input  logic               clk,
    input  logic               reset,
    input  logic               vsync_i,
    input  logic               href_i,
    input  logic               pix_stb_i,
    input  vision_pkg::chroma_t u_i,
    input  vision_pkg::chroma_t v_i,
    input  vision_pkg::chroma_t u_ref_i,
    input  vision_pkg::chroma_t v_ref_i,
    output logic               hit_stb_o,
    output logic               frame_end_o,
    output vision_pkg::coord_t  hit_x_o,
    output vision_pkg::coord_t  hit_y_o
);
    import vision_pkg::*;

    logic   href_q;
    logic   vsync_q;
    logic   href_fall;
    logic   vsync_rise;
    coord_t x_cnt;
    coord_t y_cnt;
    logic   chroma_match;
    logic   in_frame;
    logic   pix_hit;

    function automatic chroma_t abs_diff(input chroma_t a, input chroma_t b);
        return (a >= b) ? (a - b) : (b - a);
    endfunction

    assign href_fall  = href_q & ~href_i;
    assign vsync_rise = vsync_i & ~vsync_q;

    // Both chroma channels inside the tolerance window
    assign chroma_match = (abs_diff(u_i, u_ref_i) <= CHROMA_TOL) &&
                          (abs_diff(v_i, v_ref_i) <= CHROMA_TOL);

    assign in_frame = (x_cnt < FRAME_W) && (y_cnt < FRAME_H);
    assign pix_hit  = pix_stb_i && href_i && in_frame && chroma_match;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            href_q      <= 1'b0;
            vsync_q     <= 1'b0;
            x_cnt       <= '0;
            y_cnt       <= '0;
            hit_stb_o   <= 1'b0;
            frame_end_o <= 1'b0;
        end else begin
            href_q      <= href_i;
            vsync_q     <= vsync_i;
            hit_stb_o   <= pix_hit;
            frame_end_o <= vsync_rise;

            // Counters stop at the frame edge so overlong lines stay out of range
            if (href_fall) begin
                x_cnt <= '0;
            end else if (pix_stb_i && href_i && (x_cnt < FRAME_W)) begin
                x_cnt <= x_cnt + 1'b1;
            end

            if (vsync_rise) begin
                y_cnt <= '0;
            end else if (href_fall && (y_cnt < FRAME_H)) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // Position of the strobed pixel, qualified by hit_stb_o
    always_ff @(posedge clk) begin
        hit_x_o <= x_cnt;
        hit_y_o <= y_cnt;
    end

endmodule

//--- vision_pkg.sv
package vision_pkg;

    ////////////////////////////////
    // Types
    ////////////////////////////////

    // Pixel coordinate, covers 0..1023
    typedef logic [9:0] coord_t;

    // One U or V sample
    typedef logic [7:0] chroma_t;

    // Display colour channel
    typedef logic [6:0] luma_t;

    // Box area, 11 bits by 11 bits
    typedef logic [21:0] area_t;

    typedef logic [15:0] thresh_t;

    typedef enum logic {
        OVERLAY_OFF = 1'b0,
        OVERLAY_RED = 1'b1
    } overlay_mode_e;

    ////////////////////////////////
    // Frame geometry
    ////////////////////////////////

    localparam int FRAME_W = 640;
    localparam int FRAME_H = 480;

    // Square regions of 160 pixels, row major
    localparam int REGION_SIZE  = 160;
    localparam int REGION_COLS  = 4;
    localparam int REGION_ROWS  = 3;
    localparam int REGION_COUNT = REGION_COLS * REGION_ROWS;

    // Min field value of a region without hits
    localparam coord_t COORD_EMPTY = 10'd641;

    ////////////////////////////////
    // Tracking and filtering
    ////////////////////////////////

    localparam int SAMPLE_PERIOD = 5;
    localparam int CHROMA_TOL = 16;
    localparam thresh_t AREA_THRESH_DEFAULT = 16'd16;

endpackage
